/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = udp_tx_tb
FILE_LIST = src.f

BUILD_DIR = obj_dir
LOG       = sim.log
PASS_TEXT = Finished with no errors
SOURCES   = $(wildcard source/*.sv bench/*.sv bench/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

# The log decides pass or fail, not the simulator's exit status
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter real PERIOD_NS = 8.0
) (
    output logic clk
);

    // Starts low, so time zero carries no clock edge
    logic clk_r = 1'b0;

    always #(PERIOD_NS / 2.0) clk_r = ~clk_r;

    assign clk = clk_r;

endmodule

`default_nettype wire

/* bench/udp_tx_model.svh */
`ifndef UDP_TX_MODEL_SVH
`define UDP_TX_MODEL_SVH

// Whole frame as sent, first wire byte in the top bits
typedef logic [8*(FRAME_NIBBLES/2)-1:0] frame_bits_t;
typedef logic [8*IP_HEADER_BYTES-1:0] ip_header_t;

// Byte i of the frame in wire order
function automatic octet_t frame_byte(input frame_bits_t frame, input int i);
    return frame[8*(FRAME_NIBBLES/2 - 1 - i) +: 8];
endfunction

// Numerical Recipes LCG constants
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// IPv4 header, no options, with the given checksum field
function automatic ip_header_t ip_header(input ip_addr_t src_ip, input ip_addr_t dest_ip,
                                         input logic [15:0] csum);
    return {IP_VERSION, IP_IHL, IP_TOS, 16'(IP_BYTES),
            16'h0000, 16'h0000,
            IP_TTL, IP_PROTOCOL_UDP, csum,
            src_ip, dest_ip};
endfunction

// One's complement sum of the ten header words, end-around carry on every add
function automatic logic [15:0] model_ip_checksum(input ip_addr_t src_ip,
                                                  input ip_addr_t dest_ip);
    ip_header_t  hdr;
    logic [15:0] sum;
    logic [16:0] acc;
    hdr = ip_header(src_ip, dest_ip, 16'h0000);
    sum = '0;
    for (int k = 0; k < IP_HEADER_BYTES / 2; k++) begin
        acc = {1'b0, sum} + {1'b0, hdr[8*IP_HEADER_BYTES - 16 - 16*k +: 16]};
        sum = acc[15:0] + {15'b0, acc[16]};
    end
    return ~sum;
endfunction

// Bit-serial Ethernet CRC-32, each byte least significant bit first
function automatic crc_t model_crc32(input frame_bits_t frame, input int num_bytes);
    crc_t   crc;
    octet_t b;
    logic   feedback;
    crc = 32'hFFFFFFFF;
    for (int i = 0; i < num_bytes; i++) begin
        b = frame_byte(frame, i);
        for (int j = 0; j < 8; j++) begin
            feedback = crc[0] ^ b[j];
            crc = crc >> 1;
            if (feedback) begin
                crc = crc ^ CRC_POLY_REFLECTED;
            end
        end
    end
    return ~crc;
endfunction

// Expected 64 bytes, FCS appended low byte first
function automatic frame_bits_t build_frame(input payload_t data,
                                            input mac_addr_t src_mac,
                                            input mac_addr_t dest_mac,
                                            input ip_addr_t src_ip,
                                            input ip_addr_t dest_ip,
                                            input udp_port_t src_port,
                                            input udp_port_t dest_port);
    frame_bits_t frame;
    logic [15:0] csum;
    crc_t        fcs;
    csum  = model_ip_checksum(src_ip, dest_ip);
    frame = {dest_mac, src_mac, ETHER_TYPE_IPV4,
             ip_header(src_ip, dest_ip, csum),
             src_port, dest_port, 16'(UDP_BYTES), 16'h0000,
             data, 32'h0};
    fcs = model_crc32(frame, FCS_START_NIBBLE / 2);
    frame[31:0] = {fcs[7:0], fcs[15:8], fcs[23:16], fcs[31:24]};
    return frame;
endfunction

`endif

/* bench/udp_tx_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module udp_tx_tb
    import eth_proto_pkg::*;
    import udp_tx_pkg::*;
();

    // PHY transmit clock toggles every 5 system clock cycles
    localparam int TX_CLK_HALF   = 5;
    localparam int RESET_CYCLES  = 4;
    localparam int RANDOM_FRAMES = 6;
    // Eight frames of nibbles and gap in clk cycles plus some slack
    localparam int TIMEOUT_CYCLES =
        8 * ((FRAME_NIBBLES + GAP_NIBBLES + 1) * 2 * TX_CLK_HALF) + 500;

    logic      clk;
    logic      reset;
    payload_t  data;
    mac_addr_t src_mac;
    mac_addr_t dest_mac;
    ip_addr_t  src_ip;
    ip_addr_t  dest_ip;
    udp_port_t src_port;
    udp_port_t dest_port;
    logic      send;
    logic      eth_tx_clk;
    logic      ready;
    logic      eth_ref_clk;
    logic      eth_rstn;
    logic      eth_tx_en;
    nibble_t   eth_tx_d;

    `include "udp_tx_model.svh"

    logic [31:0] rng_state = 32'd68;
    string test_name = "none";
    int test_errors = 0;
    int total_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycle_count = 0;

    // Monitor state
    nibble_t captured[$];
    int frames_started = 0;
    int gaps_done = 0;
    int gap_falls = 0;
    int last_gap_falls = 0;
    logic in_gap = 1'b0;
    logic en_last = 1'b0;
    logic tx_clk_last = 1'b0;

    tb_clock #(
        .PERIOD_NS(8.0)
    ) u_tb_clock (
        .clk(clk)
    );

    udp_tx_top u_udp_tx_top (
        .clk        (clk),
        .reset      (reset),
        .data       (data),
        .src_mac    (src_mac),
        .dest_mac   (dest_mac),
        .src_ip     (src_ip),
        .dest_ip    (dest_ip),
        .src_port   (src_port),
        .dest_port  (dest_port),
        .send       (send),
        .eth_tx_clk (eth_tx_clk),
        .ready      (ready),
        .eth_ref_clk(eth_ref_clk),
        .eth_rstn   (eth_rstn),
        .eth_tx_en  (eth_tx_en),
        .eth_tx_d   (eth_tx_d)
    );

    // Free-running PHY transmit clock unrelated to the DUT state
    initial begin : tx_clk_model
        eth_tx_clk <= 1'b0;
        forever begin
            repeat (TX_CLK_HALF) @(negedge clk);
            eth_tx_clk <= ~eth_tx_clk;
        end
    end

    // PHY samples the nibble on its rising transmit clock
    always @(posedge eth_tx_clk) begin
        if (eth_tx_en) begin
            captured.push_back(eth_tx_d);
        end
    end

    // Counts frame starts and the tx_clk falls between the end of a frame and ready
    always @(negedge clk) begin
        en_last     <= eth_tx_en;
        tx_clk_last <= eth_tx_clk;
        if (eth_tx_en && !en_last) begin
            frames_started <= frames_started + 1;
        end
        if (en_last && !eth_tx_en) begin
            in_gap    <= 1'b1;
            gap_falls <= 0;
        end else if (in_gap) begin
            if (ready) begin
                in_gap         <= 1'b0;
                last_gap_falls <= gap_falls;
                gaps_done      <= gaps_done + 1;
            end else if (tx_clk_last && !eth_tx_clk) begin
                gap_falls <= gap_falls + 1;
            end
        end
    end

    initial begin : watchdog
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, test %s never finished", cycle_count, test_name);
        $display("Finished with errors");
        $finish;
    end

    function automatic logic [15:0] rand16();
        rng_state = lcg_next(rng_state);
        return rng_state[31:16];
    endfunction

    function automatic logic [31:0] rand32();
        logic [15:0] hi;
        hi = rand16();
        return {hi, rand16()};
    endfunction

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name, test_errors);
        end
    endtask

    task automatic report_mismatch(input string what, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("error %s %s: expected 0x%0h, actual 0x%0h",
                 test_name, what, expected, actual);
        test_errors++;
    endtask

    // New payload, addresses and ports on the DUT inputs
    task automatic randomize_inputs();
        for (int k = 0; k < DATA_BYTES / 2; k++) begin
            data[16*k +: 16] = rand16();
        end
        src_mac[47:32]  = rand16();
        src_mac[31:0]   = rand32();
        dest_mac[47:32] = rand16();
        dest_mac[31:0]  = rand32();
        src_ip          = rand32();
        dest_ip         = rand32();
        src_port        = rand16();
        dest_port       = rand16();
    endtask

    task automatic check_ref_clk();
        logic prev;
        int   last_rise;
        int   rises;
        int   highs;
        begin_test("ref_clk");
        prev      = eth_ref_clk;
        last_rise = -1;
        rises     = 0;
        highs     = 0;
        for (int i = 0; i < 4 * CLK_DIVIDER; i++) begin
            @(negedge clk);
            if (eth_ref_clk) begin
                highs++;
            end
            if (eth_ref_clk && !prev) begin
                if (last_rise >= 0 && i - last_rise != CLK_DIVIDER) begin
                    report_mismatch("rise spacing", CLK_DIVIDER, i - last_rise);
                end
                last_rise = i;
                rises++;
            end
            prev = eth_ref_clk;
        end
        if (rises != 4) begin
            report_mismatch("rising edges", 4, rises);
        end
        // An even divider keeps half of every period high
        if (highs != 2 * CLK_DIVIDER) begin
            report_mismatch("high cycles", 2 * CLK_DIVIDER, highs);
        end
        end_test();
    endtask

    // One send plus a second edge mid-frame when second_send is set
    task automatic run_frame(input string name, input bit second_send);
        frame_bits_t expected;
        octet_t      got;
        crc_t        got_fcs;
        int          idle;
        int          first;
        int          started_before;
        int          gaps_before;
        begin_test(name);
        idle = int'(rand16() % 16'd21);
        repeat (idle) @(negedge clk);
        if (ready !== 1'b1) begin
            report_mismatch("ready before send", 1, ready);
        end
        randomize_inputs();
        expected = build_frame(data, src_mac, dest_mac, src_ip, dest_ip,
                               src_port, dest_port);
        first          = captured.size();
        started_before = frames_started;
        gaps_before    = gaps_done;
        send = 1'b1;
        @(negedge clk);
        if (ready !== 1'b0) begin
            report_mismatch("ready after send", 0, ready);
        end
        send = 1'b0;
        if (second_send) begin
            // Edge lands while the frame is on the wire
            while (captured.size() < first + 16) @(negedge clk);
            randomize_inputs();
            send = 1'b1;
            @(negedge clk);
            send = 1'b0;
        end
        while (gaps_done == gaps_before) @(negedge clk);
        if (second_send) begin
            repeat (8 * TX_CLK_HALF) @(negedge clk);
            if (ready !== 1'b1) begin
                report_mismatch("ready after gap", 1, ready);
            end
        end
        if (frames_started != started_before + 1) begin
            report_mismatch("frames started", started_before + 1, frames_started);
        end
        if (captured.size() - first != FRAME_NIBBLES) begin
            report_mismatch("nibble count", FRAME_NIBBLES, captured.size() - first);
        end else begin
            for (int i = 0; i < FCS_START_NIBBLE / 2; i++) begin
                got = {captured[first + 2*i + 1], captured[first + 2*i]};
                if (got !== frame_byte(expected, i)) begin
                    report_mismatch($sformatf("byte %0d", i), frame_byte(expected, i), got);
                end
            end
            // FCS nibbles go out low nibble of the CRC first
            for (int n = 0; n < 8; n++) begin
                got_fcs[4*n +: 4] = captured[first + FCS_START_NIBBLE + n];
            end
            if (got_fcs !== model_crc32(expected, FCS_START_NIBBLE / 2)) begin
                report_mismatch("fcs", model_crc32(expected, FCS_START_NIBBLE / 2), got_fcs);
            end
        end
        if (last_gap_falls < GAP_NIBBLES) begin
            report_mismatch("gap tx_clk falls", GAP_NIBBLES, last_gap_falls);
        end
        end_test();
    endtask

    initial begin : stimulus
        reset     = 1'b1;
        send      = 1'b0;
        data      = '0;
        src_mac   = '0;
        dest_mac  = '0;
        src_ip    = '0;
        dest_ip   = '0;
        src_port  = '0;
        dest_port = '0;

        begin_test("reset_state");
        repeat (RESET_CYCLES) @(negedge clk);
        if (eth_rstn !== 1'b0) begin
            report_mismatch("eth_rstn in reset", 0, eth_rstn);
        end
        if (ready !== 1'b1) begin
            report_mismatch("ready in reset", 1, ready);
        end
        if (eth_tx_en !== 1'b0) begin
            report_mismatch("eth_tx_en in reset", 0, eth_tx_en);
        end
        if (eth_tx_d !== 4'h0) begin
            report_mismatch("eth_tx_d in reset", 0, eth_tx_d);
        end
        if (eth_ref_clk !== 1'b0) begin
            report_mismatch("eth_ref_clk in reset", 0, eth_ref_clk);
        end
        reset = 1'b0;
        @(negedge clk);
        if (eth_rstn !== 1'b1) begin
            report_mismatch("eth_rstn after reset", 1, eth_rstn);
        end
        if (ready !== 1'b1) begin
            report_mismatch("ready after reset", 1, ready);
        end
        if (eth_tx_en !== 1'b0) begin
            report_mismatch("eth_tx_en after reset", 0, eth_tx_en);
        end
        end_test();

        check_ref_clk();
        for (int k = 0; k < RANDOM_FRAMES; k++) begin
            run_frame($sformatf("frame_%0d", k), 1'b0);
        end
        run_frame("ignored_send", 1'b1);

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/crc32_nibble.sv */
`timescale 1ns/1ps
`default_nettype none

module crc32_nibble
    import eth_proto_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       crc_init,
    input  logic       crc_step,
    input  nibble_t    crc_nibble,
    input  logic [2:0] fcs_nibble_sel,
    output nibble_t    fcs_nibble
);

    crc_t crc;
    crc_t fcs;

    // Four bits of the reflected shift, least significant bit first
    function automatic crc_t crc_next(input crc_t cur, input nibble_t nib);
        crc_t next;
        next = cur;
        for (int j = 0; j < 4; j++) begin
            if (next[0] ^ nib[j]) begin
                next = (next >> 1) ^ CRC_POLY_REFLECTED;
            end else begin
                next = next >> 1;
            end
        end
        return next;
    endfunction

    always_ff @(posedge clk) begin
        if (reset || crc_init) begin
            crc <= CRC_INIT_VALUE;
        end else if (crc_step) begin
            crc <= crc_next(crc, crc_nibble);
        end
    end

    // Complemented register goes out low byte first, low nibble first
    assign fcs        = ~crc;
    assign fcs_nibble = fcs[4*fcs_nibble_sel +: 4];

endmodule

`default_nettype wire

/* source/eth_proto_pkg.sv */
`default_nettype none

package eth_proto_pkg;

    // Field types as they appear on the wire
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [3:0]  nibble_t;
    typedef logic [7:0]  octet_t;
    typedef logic [31:0] crc_t;

    // Header sizes in bytes
    localparam int unsigned ETHER_HEADER_BYTES = 14;
    localparam int unsigned IP_HEADER_BYTES    = 20;
    localparam int unsigned UDP_HEADER_BYTES   = 8;
    localparam int unsigned FCS_BYTES          = 4;

    // EtherType for an IPv4 payload
    localparam logic [15:0] ETHER_TYPE_IPV4 = 16'h0800;

    // IPv4 version and header length in 32-bit words
    localparam logic [3:0] IP_VERSION = 4'd4;
    localparam logic [3:0] IP_IHL     = 4'd5;

    // Type of service asks for high throughput and reliability
    localparam logic [7:0] IP_TOS = 8'h0C;

    // Datagrams are never fragmented
    localparam logic [15:0] IP_ID         = 16'h0000;
    localparam logic [15:0] IP_FLAGS_FRAG = 16'h0000;

    // Maximum hop count
    localparam logic [7:0] IP_TTL = 8'hFF;

    // Next level protocol is UDP
    localparam logic [7:0] IP_PROTOCOL_UDP = 8'h11;

    // UDP checksum is optional over IPv4 and stays zero
    localparam logic [15:0] UDP_CHECKSUM = 16'h0000;

    // Ethernet CRC-32 polynomial 0x04C11DB7 with its bits reversed
    localparam crc_t CRC_POLY_REFLECTED = 32'hEDB88320;

    // Register value before the first nibble
    localparam crc_t CRC_INIT_VALUE = 32'hFFFFFFFF;

endpackage

`default_nettype wire

/* source/frame_store.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_store
    import eth_proto_pkg::*;
    import udp_tx_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          load,
    input  payload_t      data,
    input  mac_addr_t     src_mac,
    input  mac_addr_t     dest_mac,
    input  ip_addr_t      src_ip,
    input  ip_addr_t      dest_ip,
    input  udp_port_t     src_port,
    input  udp_port_t     dest_port,
    input  logic [15:0]   checksum,
    input  nibble_index_t nibble_index,
    output ip_addr_t      lat_src_ip,
    output ip_addr_t      lat_dest_ip,
    output nibble_t       nibble
);

    payload_t  lat_data;
    mac_addr_t lat_src_mac;
    mac_addr_t lat_dest_mac;
    udp_port_t lat_src_port;
    udp_port_t lat_dest_port;

    // Headers and payload, first wire byte in the top bits
    logic [8*(HEADER_BYTES+DATA_BYTES)-1:0] body;
    octet_t byte_sel;

    always_ff @(posedge clk) begin
        if (reset) begin
            lat_data      <= '0;
            lat_src_mac   <= '0;
            lat_dest_mac  <= '0;
            lat_src_ip    <= '0;
            lat_dest_ip   <= '0;
            lat_src_port  <= '0;
            lat_dest_port <= '0;
        end else if (load) begin
            lat_data      <= data;
            lat_src_mac   <= src_mac;
            lat_dest_mac  <= dest_mac;
            lat_src_ip    <= src_ip;
            lat_dest_ip   <= dest_ip;
            lat_src_port  <= src_port;
            lat_dest_port <= dest_port;
        end
    end

    // Ethernet, IPv4 and UDP headers in network byte order
    // Payload follows with its most significant byte first
    assign body = {
        lat_dest_mac, lat_src_mac, ETHER_TYPE_IPV4,
        IP_VERSION, IP_IHL, IP_TOS, 16'(IP_BYTES),
        IP_ID, IP_FLAGS_FRAG,
        IP_TTL, IP_PROTOCOL_UDP, checksum,
        lat_src_ip, lat_dest_ip,
        lat_src_port, lat_dest_port, 16'(UDP_BYTES), UDP_CHECKSUM,
        lat_data
    };

    always_comb begin
        byte_sel = '0;
        // FCS region reads as zero
        if (nibble_index < FCS_START_NIBBLE) begin
            byte_sel = body[8 * (HEADER_BYTES + DATA_BYTES - 1 - nibble_index[7:1]) +: 8];
        end
        // Low nibble of each byte goes out first
        nibble = nibble_index[0] ? byte_sel[7:4] : byte_sel[3:0];
    end

endmodule

`default_nettype wire

/* source/ip_checksum.sv */
`timescale 1ns/1ps
`default_nettype none

module ip_checksum
    import eth_proto_pkg::*;
    import udp_tx_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  ip_addr_t    src_ip,
    input  ip_addr_t    dest_ip,
    output logic [15:0] checksum,
    output logic        checksum_valid
);

    // Addresses arrive from the frame store one cycle after start
    logic sum_pending;
    logic [31:0] sum;
    logic [16:0] fold_once;
    logic [15:0] fold_twice;

    always_ff @(posedge clk) begin
        if (reset) begin
            sum_pending    <= 1'b0;
            checksum_valid <= 1'b0;
        end else begin
            sum_pending <= start;
            if (start) begin
                checksum_valid <= 1'b0;
            end else if (sum_pending) begin
                checksum_valid <= 1'b1;
            end
        end
    end

    // Stage one sums the ten header words with the checksum word counted as zero
    always_ff @(posedge clk) begin
        if (sum_pending) begin
            sum <= {IP_VERSION, IP_IHL, IP_TOS}
                + 16'(IP_BYTES)
                + IP_ID
                + IP_FLAGS_FRAG
                + {IP_TTL, IP_PROTOCOL_UDP}
                + src_ip[31:16] + src_ip[15:0]
                + dest_ip[31:16] + dest_ip[15:0];
        end
    end

    // Stage two folds the carries back in and complements
    assign fold_once  = {1'b0, sum[31:16]} + {1'b0, sum[15:0]};
    assign fold_twice = fold_once[15:0] + {15'b0, fold_once[16]};
    assign checksum   = ~fold_twice;

    // Valid stays low for the cycle after start and returns once the sum is registered
    a_not_valid_after_start: assert property (@(posedge clk) disable iff (reset)
        start |=> !checksum_valid ##1 checksum_valid);

endmodule

`default_nettype wire

/* source/phy_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module phy_clk_gen #(
    parameter int unsigned DIVIDER = 2
) (
    input  logic clk,
    input  logic reset,
    output logic ref_clk
);

    // Position inside one output period
    logic [$clog2(DIVIDER)-1:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count   <= '0;
            ref_clk <= 1'b0;
        end else begin
            // Upper half of the count gives the high phase
            ref_clk <= (count >= DIVIDER / 2);
            if (count == DIVIDER - 1) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    // Output must keep toggling once out of reset
    a_ref_clk_toggles: assert property (@(posedge clk) disable iff (reset)
        ref_clk |-> ##[1:DIVIDER] !ref_clk);

endmodule

`default_nettype wire

/* source/udp_tx_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module udp_tx_ctrl
    import eth_proto_pkg::*;
    import udp_tx_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          send,
    input  logic          eth_tx_clk,
    input  logic          checksum_valid,
    input  nibble_t       frame_nibble,
    input  nibble_t       fcs_nibble,
    output logic          load,
    output logic          crc_init,
    output logic          crc_step,
    output nibble_index_t nibble_index,
    output nibble_t       crc_nibble,
    output logic [2:0]    fcs_nibble_sel,
    output logic          ready,
    output logic          eth_rstn,
    output logic          eth_tx_en,
    output nibble_t       eth_tx_d
);

    tx_state_t state;
    nibble_index_t count;

    logic send_prev;
    logic send_rise;
    logic tx_clk_meta;
    logic tx_clk_sync;
    logic tx_clk_prev;
    logic tx_fall;
    logic in_fcs;

    // Starts high so a send held through reset is not an edge
    always_ff @(posedge clk) begin
        if (reset) begin
            send_prev <= 1'b1;
        end else begin
            send_prev <= send;
        end
    end
    assign send_rise = send && !send_prev;

    // PHY transmit clock is asynchronous to clk
    always_ff @(posedge clk) begin
        if (reset) begin
            tx_clk_meta <= 1'b0;
            tx_clk_sync <= 1'b0;
            tx_clk_prev <= 1'b0;
        end else begin
            tx_clk_meta <= eth_tx_clk;
            tx_clk_sync <= tx_clk_meta;
            tx_clk_prev <= tx_clk_sync;
        end
    end
    assign tx_fall = tx_clk_prev && !tx_clk_sync;

    // Start edge only counts while idle
    assign load     = (state == READY) && send_rise;
    assign crc_init = load;

    assign nibble_index   = count;
    assign in_fcs         = (count >= FCS_START_NIBBLE);
    assign crc_nibble     = frame_nibble;
    assign crc_step       = (state == SEND_FRAME) && tx_fall && !in_fcs;
    assign fcs_nibble_sel = 3'(count - FCS_START_NIBBLE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= READY;
            count     <= '0;
            ready     <= 1'b1;
            eth_rstn  <= 1'b0;
            eth_tx_en <= 1'b0;
            eth_tx_d  <= '0;
        end else begin
            eth_rstn <= 1'b1;
            case (state)
                READY: begin
                    if (load) begin
                        ready <= 1'b0;
                        count <= '0;
                        state <= CHECKSUM;
                    end
                end
                // Header checksum must be final before the IP header goes out
                CHECKSUM: begin
                    if (checksum_valid) begin
                        state <= SEND_FRAME;
                    end
                end
                SEND_FRAME: begin
                    if (tx_fall) begin
                        if (count < FRAME_NIBBLES) begin
                            eth_tx_en <= 1'b1;
                            eth_tx_d  <= in_fcs ? fcs_nibble : frame_nibble;
                            count     <= count + 1'b1;
                        end else begin
                            // Fall after the last nibble ends the frame
                            eth_tx_en <= 1'b0;
                            eth_tx_d  <= '0;
                            count     <= '0;
                            state     <= GAP;
                        end
                    end
                end
                GAP: begin
                    if (tx_fall) begin
                        if (count == GAP_NIBBLES - 1) begin
                            ready <= 1'b1;
                            state <= READY;
                        end else begin
                            count <= count + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= READY;
                end
            endcase
        end
    end

    a_tx_en_in_frame: assert property (@(posedge clk) disable iff (reset)
        (state != SEND_FRAME) |-> !eth_tx_en);

    a_ready_when_idle: assert property (@(posedge clk) disable iff (reset)
        ready |-> (state == READY));

endmodule

`default_nettype wire

/* source/udp_tx_pkg.sv */
`default_nettype none

package udp_tx_pkg;
    import eth_proto_pkg::*;

    // Fixed payload size, gives the 64-byte minimum frame
    localparam int unsigned DATA_BYTES = 18;

    // Values of the UDP and IPv4 length fields
    localparam int unsigned UDP_BYTES = UDP_HEADER_BYTES + DATA_BYTES;
    localparam int unsigned IP_BYTES  = IP_HEADER_BYTES + UDP_BYTES;

    // All headers in front of the payload
    localparam int unsigned HEADER_BYTES =
        ETHER_HEADER_BYTES + IP_HEADER_BYTES + UDP_HEADER_BYTES;

    // Nibbles on the wire, FCS included
    localparam int unsigned FRAME_NIBBLES = 2 * (HEADER_BYTES + DATA_BYTES + FCS_BYTES);

    // First nibble taken from the CRC instead of the frame store
    localparam int unsigned FCS_START_NIBBLE = 2 * (HEADER_BYTES + DATA_BYTES);

    // Interframe gap of 12 bytes
    localparam int unsigned GAP_NIBBLES = 24;

    // System clock cycles per PHY reference clock period
    localparam int unsigned CLK_DIVIDER = 4;

    typedef logic [8*DATA_BYTES-1:0] payload_t;
    typedef logic [7:0] nibble_index_t;

    typedef enum logic [1:0] {
        READY,
        CHECKSUM,
        SEND_FRAME,
        GAP
    } tx_state_t;

endpackage

`default_nettype wire

/* source/udp_tx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module udp_tx_top
    import eth_proto_pkg::*;
    import udp_tx_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  payload_t  data,
    input  mac_addr_t src_mac,
    input  mac_addr_t dest_mac,
    input  ip_addr_t  src_ip,
    input  ip_addr_t  dest_ip,
    input  udp_port_t src_port,
    input  udp_port_t dest_port,
    input  logic      send,
    input  logic      eth_tx_clk,
    output logic      ready,
    output logic      eth_ref_clk,
    output logic      eth_rstn,
    output logic      eth_tx_en,
    output nibble_t   eth_tx_d
);

    logic          load;
    logic          crc_init;
    logic          crc_step;
    logic          checksum_valid;
    logic [15:0]   checksum;
    logic [2:0]    fcs_nibble_sel;
    nibble_index_t nibble_index;
    nibble_t       frame_nibble;
    nibble_t       fcs_nibble;
    nibble_t       crc_nibble;
    ip_addr_t      lat_src_ip;
    ip_addr_t      lat_dest_ip;

    phy_clk_gen #(
        .DIVIDER(CLK_DIVIDER)
    ) u_phy_clk_gen (
        .clk    (clk),
        .reset  (reset),
        .ref_clk(eth_ref_clk)
    );

    // Checksum starts on the same pulse that latches the fields
    ip_checksum u_ip_checksum (
        .clk           (clk),
        .reset         (reset),
        .start         (load),
        .src_ip        (lat_src_ip),
        .dest_ip       (lat_dest_ip),
        .checksum      (checksum),
        .checksum_valid(checksum_valid)
    );

    frame_store u_frame_store (
        .clk         (clk),
        .reset       (reset),
        .load        (load),
        .data        (data),
        .src_mac     (src_mac),
        .dest_mac    (dest_mac),
        .src_ip      (src_ip),
        .dest_ip     (dest_ip),
        .src_port    (src_port),
        .dest_port   (dest_port),
        .checksum    (checksum),
        .nibble_index(nibble_index),
        .lat_src_ip  (lat_src_ip),
        .lat_dest_ip (lat_dest_ip),
        .nibble      (frame_nibble)
    );

    crc32_nibble u_crc32_nibble (
        .clk           (clk),
        .reset         (reset),
        .crc_init      (crc_init),
        .crc_step      (crc_step),
        .crc_nibble    (crc_nibble),
        .fcs_nibble_sel(fcs_nibble_sel),
        .fcs_nibble    (fcs_nibble)
    );

    udp_tx_ctrl u_udp_tx_ctrl (
        .clk           (clk),
        .reset         (reset),
        .send          (send),
        .eth_tx_clk    (eth_tx_clk),
        .checksum_valid(checksum_valid),
        .frame_nibble  (frame_nibble),
        .fcs_nibble    (fcs_nibble),
        .load          (load),
        .crc_init      (crc_init),
        .crc_step      (crc_step),
        .nibble_index  (nibble_index),
        .crc_nibble    (crc_nibble),
        .fcs_nibble_sel(fcs_nibble_sel),
        .ready         (ready),
        .eth_rstn      (eth_rstn),
        .eth_tx_en     (eth_tx_en),
        .eth_tx_d      (eth_tx_d)
    );

endmodule

`default_nettype wire

/* src.f */
+incdir+bench
source/eth_proto_pkg.sv
source/udp_tx_pkg.sv
source/phy_clk_gen.sv
source/ip_checksum.sv
source/frame_store.sv
source/crc32_nibble.sv
source/udp_tx_ctrl.sv
source/udp_tx_top.sv
bench/tb_clock.sv
bench/udp_tx_tb.sv
